// ==== all.f ====
+incdir+design
design/audio_pkg.sv
design/bridge_regs.sv
design/sample_fifo.sv
design/i2s_serializer.sv
design/audio_core_top.sv
sim/tb_audio_core.sv

// ==== sim/tb_audio_core.sv ====
// testbench for the audio core
// drives the host bridge, decodes the i2s stream back into stereo frames,
// and runs directed tests against the register map and frame contents

`timescale 1ns/100ps
`include "audio_cfg.svh"

module tb_audio_core;

    // register addresses at word offsets 0..3 in the block
    localparam logic [31:0] ADDR_CTRL     = {`AUD_BRIDGE_BASE, 24'h000000};
    localparam logic [31:0] ADDR_SAMPLE   = {`AUD_BRIDGE_BASE, 24'h000004};
    localparam logic [31:0] ADDR_STATUS   = {`AUD_BRIDGE_BASE, 24'h000008};
    localparam logic [31:0] ADDR_UNDERRUN = {`AUD_BRIDGE_BASE, 24'h00000C};
    localparam int FRAME_CLKS = 2 * `AUD_SLOT_BITS * `AUD_SCLK_DIV;
    // bit clock period in ns for the 4 ns master clock
    localparam int SCLK_NS = 4 * `AUD_SCLK_DIV;

    logic        audgen_mclk = 1'b0;
    logic        reset_n;
    logic [31:0] bridge_addr;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic        bridge_rd;
    logic [31:0] bridge_rd_data;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    int          errors = 0;
    int          timeouts = 0;
    integer      seed = 51587;

    // received frames with left in the upper half
    logic [31:0] rx_frames [$];

    audio_core_top dut (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    // 4 ns master clock
    always #2 audgen_mclk = ~audgen_mclk;

    //////////////////////////////////////////////////
    // i2s receiver

    logic        rx_prev_lrck = 1'b0;
    logic        rx_synced = 1'b0;
    logic        rx_left_ok = 1'b0;
    logic [15:0] rx_left = '0;
    logic [15:0] rx_right = '0;
    int          rx_cnt = 0;
    time         rx_last_rise = 0;

    // dac is stable on rising sclk; nothing counts until the first lrck change
    always @(posedge audio_sclk) begin
        if (reset_n) begin
            if (rx_last_rise != 0 && ($time - rx_last_rise) != SCLK_NS) begin
                $display("MISMATCH at %0t: sclk period %0t, expected %0d",
                         $time, $time - rx_last_rise, SCLK_NS);
                errors++;
            end
            rx_last_rise = $time;
            if (audio_lrck != rx_prev_lrck) begin
                if (rx_synced && rx_cnt != `AUD_SLOT_BITS) begin
                    $display("MISMATCH at %0t: slot had %0d bits", $time, rx_cnt);
                    errors++;
                end
                rx_synced = 1'b1;
                rx_cnt = 0;
            end
            rx_prev_lrck = audio_lrck;
            if (rx_synced) begin
                if (rx_cnt < `AUD_SAMPLE_W) begin
                    if (audio_lrck)
                        rx_right = {rx_right[14:0], audio_dac};
                    else
                        rx_left = {rx_left[14:0], audio_dac};
                end else if (audio_dac !== 1'b0) begin
                    $display("MISMATCH at %0t: pad bit %0d is not zero", $time, rx_cnt);
                    errors++;
                end
                rx_cnt++;
                // a frame is a full left slot followed by a full right slot
                if (rx_cnt == `AUD_SLOT_BITS) begin
                    if (!audio_lrck) begin
                        rx_left_ok = 1'b1;
                    end else begin
                        if (rx_left_ok)
                            rx_frames.push_back({rx_left, rx_right});
                        rx_left_ok = 1'b0;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // bridge access and helpers

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge audgen_mclk);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge audgen_mclk);
        bridge_wr      <= 1'b0;
    endtask

    // read data is sampled mid-cycle away from the edges
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge audgen_mclk);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(negedge audgen_mclk);
        data = bridge_rd_data;
        @(posedge audgen_mclk);
        bridge_rd   <= 1'b0;
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // status layout is level in 3:0 with full at bit 8 and empty at bit 9
    function automatic logic [31:0] expect_status(input int lvl);
        logic [31:0] s;
        s = 32'(lvl);
        s[8] = (lvl == `AUD_FIFO_DEPTH);
        s[9] = (lvl == 0);
        return s;
    endfunction

    // nonzero low bit in each half so a sample never looks like silence
    function automatic logic [31:0] random_sample();
        return $random(seed) | 32'h0001_0001;
    endfunction

    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = rx_frames.size() + n;
        cycles = 0;
        while (rx_frames.size() < target && cycles < (n + 2) * FRAME_CLKS) begin
            @(posedge audgen_mclk);
            cycles++;
        end
        if (rx_frames.size() < target) begin
            $display("timeout: %0d frames did not arrive within %0d clocks", n, cycles);
            timeouts++;
        end
    endtask

    // skips silent frames until one carries audio
    task automatic wait_sound(output logic [31:0] frame);
        int  cycles;
        logic found;
        cycles = 0;
        found = 1'b0;
        frame = '0;
        while (!found && cycles < 4 * FRAME_CLKS) begin
            @(posedge audgen_mclk);
            cycles++;
            while (rx_frames.size() > 0 && !found) begin
                frame = rx_frames.pop_front();
                found = (frame != '0);
            end
        end
        if (!found) begin
            $display("timeout: no frame with audio within %0d clocks", cycles);
            timeouts++;
        end
    endtask

    task automatic check_silent(input string what);
        logic [31:0] f;
        while (rx_frames.size() > 0) begin
            f = rx_frames.pop_front();
            check_word(what, f, 32'h0);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests

    task automatic after_reset_values();
        logic [31:0] d;
        bus_read(ADDR_CTRL, d);
        check_word("ctrl after reset", d, 32'h0);
        bus_read(ADDR_STATUS, d);
        check_word("status after reset", d, expect_status(0));
        bus_read(ADDR_UNDERRUN, d);
        check_word("underrun after reset", d, 32'h0);
        bus_read({8'h20, ADDR_STATUS[23:0]}, d);
        check_word("foreign base byte", d, 32'h0);
        bus_read(ADDR_CTRL + 32'h10, d);
        check_word("unmapped offset", d, 32'h0);
        wait_frames(3);
        check_silent("frame after reset");
    endtask

    task automatic single_sample_path();
        logic [31:0] w;
        logic [31:0] f;
        logic [31:0] d;
        w = random_sample();
        bus_write(ADDR_CTRL, 32'h1);
        bus_write(ADDR_SAMPLE, w);
        wait_sound(f);
        check_word("single sample frame", f, w);
        bus_read(ADDR_STATUS, d);
        check_word("status after single sample", d, expect_status(0));
    endtask

    task automatic fifo_order_capacity();
        logic [31:0] words [10];
        logic [31:0] f;
        logic [31:0] d;
        bus_write(ADDR_CTRL, 32'h0);
        for (int i = 0; i < 10; i++) begin
            words[i] = random_sample();
            bus_write(ADDR_SAMPLE, words[i]);
        end
        bus_read(ADDR_STATUS, d);
        check_word("status when full", d, expect_status(`AUD_FIFO_DEPTH));
        rx_frames.delete();
        bus_write(ADDR_CTRL, 32'h1);
        for (int i = 0; i < `AUD_FIFO_DEPTH; i++) begin
            wait_sound(f);
            check_word($sformatf("ordered frame %0d", i), f, words[i]);
        end
        // words 8 and 9 were dropped, so only silence follows
        wait_frames(3);
        check_silent("frame after drain");
        bus_read(ADDR_STATUS, d);
        check_word("status after drain", d, expect_status(0));
    endtask

    task automatic underrun_counting();
        logic [31:0] u1;
        logic [31:0] u2;
        logic [31:0] u3;
        int          n;
        n = 4;
        bus_write(ADDR_CTRL, 32'h1);
        bus_write(ADDR_UNDERRUN, 32'h0);
        rx_frames.delete();
        // one extra frame covers the one already decided at the clear
        wait_frames(n + 1);
        bus_read(ADDR_UNDERRUN, u1);
        if (u1 < n || u1 > n + 2) begin
            $display("MISMATCH at %0t: underrun count %0d, expected %0d to %0d",
                     $time, u1, n, n + 2);
            errors++;
        end
        wait_frames(1);
        bus_read(ADDR_UNDERRUN, u2);
        if (u2 <= u1) begin
            $display("MISMATCH at %0t: underrun did not grow, %0d then %0d", $time, u1, u2);
            errors++;
        end
        check_silent("starved frame");
        bus_write(ADDR_UNDERRUN, 32'hFFFF_FFFF);
        rx_frames.delete();
        bus_read(ADDR_UNDERRUN, u3);
        if (u3 > rx_frames.size() + 1) begin
            $display("MISMATCH at %0t: underrun %0d after clear", $time, u3);
            errors++;
        end
    endtask

    task automatic disabled_silence();
        logic [31:0] d;
        bus_write(ADDR_CTRL, 32'h0);
        bus_write(ADDR_UNDERRUN, 32'h0);
        rx_frames.delete();
        wait_frames(1);
        bus_write(ADDR_SAMPLE, random_sample());
        wait_frames(3);
        check_silent("disabled frame");
        bus_read(ADDR_UNDERRUN, d);
        check_word("underrun while disabled", d, 32'h0);
        bus_read(ADDR_STATUS, d);
        check_word("status with one held word", d, expect_status(1));
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        reset_n        = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        repeat (4) @(posedge audgen_mclk);
        reset_n <= 1'b1;

        after_reset_values();
        single_sample_path();
        fifo_order_capacity();
        underrun_counting();
        disabled_silence();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== design/audio_core_top.sv ====
// audio core top level
// bridge register block feeding a sample buffer drained by an i2s serializer
// single clock domain on audgen_mclk

`timescale 1ns/100ps

module audio_core_top (
    input  logic        audgen_mclk,
    input  logic        reset_n,

    // host bridge bus
    input  logic [31:0] bridge_addr,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,

    // serial audio out
    output logic        audio_sclk,
    output logic        audio_lrck,
    output logic        audio_dac
);

    // producer side
    logic                push;
    audio_pkg::stereo_t  push_data;
    logic                enable;

    // buffer state
    audio_pkg::level_t   level;
    logic                full;
    logic                empty;

    // consumer side
    audio_pkg::stereo_t  head;
    logic                pop;
    logic                underrun;

    bridge_regs u_regs (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .push           (push),
        .push_data      (push_data),
        .level          (level),
        .full           (full),
        .empty          (empty),
        .underrun       (underrun),
        .enable         (enable)
    );

    sample_fifo u_fifo (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .head        (head),
        .level       (level),
        .full        (full),
        .empty       (empty)
    );

    i2s_serializer u_i2s (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .enable      (enable),
        .empty       (empty),
        .head        (head),
        .pop         (pop),
        .underrun    (underrun),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

// ==== design/i2s_serializer.sv ====
// i2s serializer
// bit clock is mclk / AUD_SCLK_DIV, 32-bit slots, left-justified 16-bit samples
// pops one stereo word per frame, or sends silence

`timescale 1ns/100ps
`include "audio_cfg.svh"

module i2s_serializer (
    input  logic                audgen_mclk,
    input  logic                reset_n,

    // control and buffer state
    input  logic                enable,
    input  logic                empty,
    input  audio_pkg::stereo_t  head,

    // buffer handshake
    output logic                pop,
    output logic                underrun,

    // serial audio out
    output logic                audio_sclk,
    output logic                audio_lrck,
    output logic                audio_dac
);

    localparam int DIV_W   = $clog2(`AUD_SCLK_DIV);
    localparam int CNT_W   = $clog2(`AUD_SLOT_BITS);
    localparam int PAD_W   = `AUD_SLOT_BITS - `AUD_SAMPLE_W;
    localparam int FRAME_W = 2 * `AUD_SLOT_BITS;

    logic [DIV_W-1:0]        div_cnt;
    logic [CNT_W-1:0]        bit_cnt;
    audio_pkg::i2s_phase_e   phase;
    audio_pkg::i2s_phase_e   phase_nxt;
    audio_pkg::stereo_t      next_word;
    logic [FRAME_W-1:0]      frame_img;
    logic [FRAME_W-2:0]      shift_q;
    logic                    bit_edge;
    logic                    slot_last;
    logic                    frame_edge;
    logic                    decide;

    //////////////////////////////////////////////////
    // bit clock divider

    // wrap from last count to 0 is the falling sclk edge
    assign bit_edge   = (div_cnt == DIV_W'(`AUD_SCLK_DIV-1));
    assign audio_sclk = div_cnt[DIV_W-1];

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= bit_edge ? '0 : div_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // slot and frame position

    assign slot_last  = (bit_cnt == CNT_W'(`AUD_SLOT_BITS-1));
    assign frame_edge = bit_edge && slot_last && (phase == audio_pkg::SLOT_RIGHT);
    assign phase_nxt  = !slot_last ? phase :
                        (phase == audio_pkg::SLOT_LEFT) ? audio_pkg::SLOT_RIGHT
                                                        : audio_pkg::SLOT_LEFT;

    // parked on the last right bit so the first boundary opens a frame
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt <= CNT_W'(`AUD_SLOT_BITS-1);
            phase   <= audio_pkg::SLOT_RIGHT;
        end else if (bit_edge) begin
            bit_cnt <= slot_last ? '0 : bit_cnt + 1'b1;
            phase   <= phase_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next frame decision, one mclk ahead of the boundary

    assign decide   = (div_cnt == DIV_W'(`AUD_SCLK_DIV-2)) && slot_last &&
                      (phase == audio_pkg::SLOT_RIGHT);
    assign pop      = decide && enable && !empty;
    assign underrun = decide && enable && empty;

    // silence when disabled or starved
    always_ff @(posedge audgen_mclk) begin
        if (decide) begin
            next_word <= (enable && !empty) ? head : '0;
        end
    end

    //////////////////////////////////////////////////
    // shift out

    // left sample, pad, right sample, pad
    assign frame_img = {next_word[2*`AUD_SAMPLE_W-1:`AUD_SAMPLE_W], {PAD_W{1'b0}},
                        next_word[`AUD_SAMPLE_W-1:0], {PAD_W{1'b0}}};

    always_ff @(posedge audgen_mclk) begin
        if (frame_edge) begin
            shift_q <= frame_img[FRAME_W-2:0];
        end else if (bit_edge) begin
            shift_q <= {shift_q[FRAME_W-3:0], 1'b0};
        end
    end

    // msb first, changes only on falling sclk
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            audio_dac  <= 1'b0;
            audio_lrck <= 1'b0;
        end else if (bit_edge) begin
            audio_lrck <= (phase_nxt == audio_pkg::SLOT_RIGHT);
            audio_dac  <= frame_edge ? frame_img[FRAME_W-1] : shift_q[FRAME_W-2];
        end
    end

endmodule

// ==== design/sample_fifo.sv ====
// stereo sample buffer
// show-ahead fifo, head always presents the oldest entry
// level counter drives full and empty

`timescale 1ns/100ps
`include "audio_cfg.svh"

module sample_fifo (
    input  logic                audgen_mclk,
    input  logic                reset_n,

    // write side
    input  logic                push,
    input  audio_pkg::stereo_t  push_data,

    // read side
    input  logic                pop,
    output audio_pkg::stereo_t  head,

    // occupancy
    output audio_pkg::level_t   level,
    output logic                full,
    output logic                empty
);

    localparam int PTR_W = $clog2(`AUD_FIFO_DEPTH);

    audio_pkg::stereo_t  mem [`AUD_FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;

    //////////////////////////////////////////////////
    // storage

    // callers guarantee push only when not full
    always_ff @(posedge audgen_mclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head = mem[rd_ptr];

    //////////////////////////////////////////////////
    // pointers and level

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`AUD_FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`AUD_FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // push and pop together leave the level alone
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            level <= '0;
        end else begin
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign full  = (level == `AUD_LEVEL_W'(`AUD_FIFO_DEPTH));
    assign empty = (level == '0);

endmodule

// ==== design/bridge_regs.sv ====
// bridge register block for the audio core
// decodes host writes and reads, holds enable and the underrun count,
// and turns sample writes into buffer pushes

`timescale 1ns/100ps
`include "audio_cfg.svh"

module bridge_regs (
    input  logic                audgen_mclk,
    input  logic                reset_n,

    // host bridge bus
    input  logic [31:0]         bridge_addr,
    input  logic                bridge_wr,
    input  logic [31:0]         bridge_wr_data,
    input  logic                bridge_rd,
    output logic [31:0]         bridge_rd_data,

    // buffer write side
    output logic                push,
    output audio_pkg::stereo_t  push_data,
    input  audio_pkg::level_t   level,
    input  logic                full,
    input  logic                empty,

    // from the serializer
    input  logic                underrun,
    output logic                enable
);

    //////////////////////////////////////////////////
    // address decode

    logic                    blk_hit;
    audio_pkg::reg_offset_e  offset;
    logic                    wr_hit;
    logic [31:0]             underrun_cnt;
    logic [31:0]             status_word;

    // top byte selects the block, bits 7:2 pick the word
    assign blk_hit = (bridge_addr[31:24] == `AUD_BRIDGE_BASE);
    assign offset  = audio_pkg::reg_offset_e'(bridge_addr[7:2]);
    assign wr_hit  = bridge_wr && blk_hit;

    //////////////////////////////////////////////////
    // sample push

    // write data goes straight into the buffer as one stereo word
    assign push_data = audio_pkg::stereo_t'(bridge_wr_data);

    // dropped silently while full
    assign push = wr_hit && (offset == audio_pkg::REG_SAMPLE) && !full;

    //////////////////////////////////////////////////
    // control and underrun registers

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            enable <= 1'b0;
        end else if (wr_hit && (offset == audio_pkg::REG_CTRL)) begin
            enable <= bridge_wr_data[0];
        end
    end

    // host clear beats a same-cycle increment
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            underrun_cnt <= '0;
        end else if (wr_hit && (offset == audio_pkg::REG_UNDERRUN)) begin
            underrun_cnt <= '0;
        end else if (underrun) begin
            underrun_cnt <= underrun_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // read mux

    // status layout: level in 3:0, full at 8, empty at 9
    always_comb begin
        status_word = '0;
        status_word[`AUD_LEVEL_W-1:0] = level;
        status_word[8] = full;
        status_word[9] = empty;
    end

    // purely combinational on the address, so reads never disturb state
    // and bridge_rd itself is not needed to steer the mux
    always_comb begin
        bridge_rd_data = '0;
        if (blk_hit) begin
            case (offset)
                audio_pkg::REG_CTRL:     bridge_rd_data = {31'd0, enable};
                audio_pkg::REG_STATUS:   bridge_rd_data = status_word;
                audio_pkg::REG_UNDERRUN: bridge_rd_data = underrun_cnt;
                // sample register is write only
                default:                 bridge_rd_data = '0;
            endcase
        end
    end

endmodule

// ==== design/audio_pkg.sv ====
// audio core shared types
// sample words, buffer level, register offsets and serializer slot phase

`include "audio_cfg.svh"

package audio_pkg;

    //////////////////////////////////////////////////
    // data types

    // one stereo word, left in upper half, right in lower half
    typedef logic [2*`AUD_SAMPLE_W-1:0] stereo_t;

    // buffer occupancy, 0 up to AUD_FIFO_DEPTH
    typedef logic [`AUD_LEVEL_W-1:0] level_t;

    //////////////////////////////////////////////////
    // register map, word offset from address bits 7:2

    typedef enum logic [5:0] {
        REG_CTRL     = 6'd0,
        REG_SAMPLE   = 6'd1,
        REG_STATUS   = 6'd2,
        REG_UNDERRUN = 6'd3
    } reg_offset_e;

    // serializer slot, matches lrck level
    typedef enum logic {
        SLOT_LEFT  = 1'b0,
        SLOT_RIGHT = 1'b1
    } i2s_phase_e;

endpackage

// ==== design/audio_cfg.svh ====
// audio core configuration
// buffer depth, sample and slot sizes, bridge base byte, bit clock divider

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// stereo entries held in the sample buffer
`define AUD_FIFO_DEPTH 8

// level count width, must hold 0..AUD_FIFO_DEPTH
`define AUD_LEVEL_W 4

// bits per channel sample
`define AUD_SAMPLE_W 16

// bits per channel slot on the wire
`define AUD_SLOT_BITS 32

// top address byte that selects this block
`define AUD_BRIDGE_BASE 8'h10

// master clocks per serial bit
`define AUD_SCLK_DIV 4

`endif
